// File: vlog.f
hdl/dcache_geom_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/dcache_way.sv
hdl/dcache_way_mux.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # packages first, then leaf modules up to the top level
  - target: rtl
    files:
      - hdl/dcache_geom_pkg.sv
      - hdl/dcache_ctrl_pkg.sv
      - hdl/dcache_way.sv
      - hdl/dcache_way_mux.sv
      - hdl/dcache_ctrl.sv
      - hdl/dcache_top.sv

  # testbench, top module tb_dcache
  - target: test
    files:
      - tb/tb_dcache.sv

// File: tb/tb_dcache.sv
// ##################################################
// testbench for the data cache top level
// burst memory model with random gaps and ready
// back-pressure, coherent reference memory, load
// checker and watchdog; top module is tb_dcache
// ##################################################
`default_nettype none

module tb_dcache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 8;
    localparam int WPL             = dcache_geom_pkg::WORDS_PER_LINE;
    localparam int N_TAGS          = 16;  // tags used by the stimulus
    localparam int MEM_WORDS       = N_TAGS * dcache_geom_pkg::SETS * WPL;
    localparam int LINE_BYTES      = WPL * dcache_geom_pkg::STRB_W;
    localparam int INDEX_SHIFT     = dcache_geom_pkg::WORD_SEL_W + dcache_geom_pkg::BYTE_OFF_W;
    localparam int TAG_SHIFT       = INDEX_SHIFT + dcache_geom_pkg::INDEX_W;
    localparam int N_DIRECTED_OPS  = 128;
    localparam int N_RAND_OPS      = 400;
    localparam int MISS_MAX_CYCLES = 80;  // write-back, refill, gaps and ready stalls
    localparam longint WATCHDOG_NS =
        longint'(N_DIRECTED_OPS + N_RAND_OPS) * MISS_MAX_CYCLES * CLK_PERIOD;

    logic                                   clk;
    logic                                   resetn;
    logic                                   valid;
    logic                                   op;
    dcache_geom_pkg::addr_t                 addr;
    logic [dcache_geom_pkg::STRB_W-1:0]     wstrb;
    logic [dcache_geom_pkg::WORD_W-1:0]     wdata;
    logic                                   addr_ok;
    logic                                   data_ok;
    logic [dcache_geom_pkg::WORD_W-1:0]     rdata;
    logic                                   rd_rdy;
    logic                                   wr_rdy;
    logic                                   ret_valid;
    logic                                   ret_last;
    logic [dcache_geom_pkg::WORD_W-1:0]     ret_data;
    logic                                   rd_req;
    logic [dcache_geom_pkg::ADDR_W-1:0]     rd_addr;
    logic                                   wr_req;
    logic [dcache_geom_pkg::ADDR_W-1:0]     wr_addr;
    logic [dcache_geom_pkg::LINE_W-1:0]     wr_data;

    logic [dcache_geom_pkg::WORD_W-1:0]     mem     [MEM_WORDS];  // bus side memory
    logic [dcache_geom_pkg::WORD_W-1:0]     ref_mem [MEM_WORDS];  // coherent view
    logic [31:0]                            lcg_state;
    logic [dcache_geom_pkg::ADDR_W-1:0]     last_rd_addr;
    logic                                   bp_on;
    int                                     rd_count;
    int                                     wr_count;
    int                                     checks;
    int                                     errors;

    dcache_top dcache_top_i (
        .clk, .resetn, .valid, .op, .addr, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_rdy, .wr_rdy, .ret_valid, .ret_last, .ret_data,
        .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 8) % n;  // upper bits since the low ones cycle fast
    endfunction

    function automatic logic [31:0] line_addr(input int unsigned tag, input int unsigned index,
                                              input int unsigned word);
        return (tag << TAG_SHIFT) | (index << INDEX_SHIFT)
             | (word << dcache_geom_pkg::BYTE_OFF_W);
    endfunction

    function automatic int unsigned word_index(input logic [31:0] a);
        return (a >> dcache_geom_pkg::BYTE_OFF_W) % MEM_WORDS;
    endfunction

    // reference model of byte lane merge and coherent load
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < dcache_geom_pkg::STRB_W; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] a);
        return ref_mem[word_index(a)];
    endfunction

    task automatic check(input string name, input logic [dcache_geom_pkg::LINE_W-1:0] got,
                         input logic [dcache_geom_pkg::LINE_W-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // one CPU request held until data_ok
    // wait_cycles of 0 means data_ok in the first cycle
    task automatic do_op(input logic is_store, input logic [31:0] a,
                         input logic [3:0] strb, input logic [31:0] data,
                         output int wait_cycles);
        @(negedge clk);
        valid     = 1'b1;
        op        = is_store;
        addr.flat = a;
        wstrb     = strb;
        wdata     = data;
        wait_cycles = 0;
        @(posedge clk);
        while (data_ok !== 1'b1) begin
            wait_cycles++;
            @(posedge clk);
        end
    endtask

    task automatic load(input logic [31:0] a);
        int cyc;
        do_op(1'b0, a, '0, '0, cyc);
    endtask

    task automatic store(input logic [31:0] a, input logic [3:0] strb, input logic [31:0] data);
        int cyc;
        do_op(1'b1, a, strb, data, cyc);
    endtask

    // compare process checks loads against the reference and merges stores into it
    always @(posedge clk) begin
        if (resetn === 1'b1 && valid && data_ok === 1'b1) begin
            if (op) begin
                ref_mem[word_index(addr.flat)] =
                    merge_bytes(ref_load(addr.flat), wdata, wstrb);
            end else begin
                check("rdata", rdata, ref_load(addr.flat));
            end
        end
    end

    // write-back side of the bus model
    always @(posedge clk) begin
        if (resetn === 1'b1 && wr_req === 1'b1) begin
            wr_count++;
            check("wr_addr offset", wr_addr % LINE_BYTES, 0);
            for (int w = 0; w < WPL; w++) begin
                check("wr_data", wr_data[w*32 +: 32], ref_mem[word_index(wr_addr) + w]);
                mem[word_index(wr_addr) + w] = wr_data[w*32 +: 32];
            end
        end
    end

    always @(negedge clk) begin
        if (bp_on) begin
            rd_rdy = rand_below(4) != 0;
            wr_rdy = rand_below(4) != 0;
        end else begin
            rd_rdy = 1'b1;
            wr_rdy = 1'b1;
        end
    end

    // refill side returns words in order with random gaps
    initial begin : bus_read
        logic [31:0] base;
        int          gap [WPL];
        forever begin
            @(posedge clk);
            if (resetn === 1'b1 && rd_req === 1'b1) begin
                rd_count++;
                last_rd_addr = rd_addr;
                check("rd_addr offset", rd_addr % LINE_BYTES, 0);
                base = rd_addr;
                for (int w = 0; w < WPL; w++) begin
                    gap[w] = bp_on ? rand_below(3) : 0;
                end
                for (int w = 0; w < WPL; w++) begin
                    repeat (gap[w]) begin
                        @(negedge clk);
                        ret_valid = 1'b0;
                        ret_last  = 1'b0;
                    end
                    @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (w == WPL - 1);
                    ret_data  = mem[word_index(base) + w];
                end
                @(negedge clk);
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a request never completed", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int          cyc;
        int          rd_before;
        int          wr_before;
        logic [31:0] a;
        logic [3:0]  strb;
        lcg_state = 32'd7516;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = lcg_next() ^ (i << 2);
            ref_mem[i] = mem[i];
        end
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        rd_rdy = 1'b1;
        wr_rdy = 1'b1;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        bp_on = 1'b0;
        rd_count = 0;
        wr_count = 0;
        checks = 0;
        errors = 0;
        resetn = 1'b0;
        repeat (2) @(negedge clk);
        resetn = 1'b1;

        @(posedge clk);
        check("rd_req", rd_req, 0);
        check("wr_req", wr_req, 0);
        check("data_ok", data_ok, 0);
        check("addr_ok", addr_ok, 1);

        // load miss and then an immediate hit on the same line
        for (int i = 0; i < 4; i++) begin
            a = line_addr(i + 1, i * 3, i);
            rd_before = rd_count;
            do_op(1'b0, a, '0, '0, cyc);
            check("rd_req count", rd_count - rd_before, 1);
            check("rd_addr", last_rd_addr, line_addr(i + 1, i * 3, 0));
            do_op(1'b0, a, '0, '0, cyc);
            check("data_ok latency", cyc, 0);
        end

        for (int p = 0; p < (1 << dcache_geom_pkg::STRB_W); p++) begin
            strb = p;
            store(line_addr(2, 9, 1), strb, lcg_next());
            load(line_addr(2, 9, 1));
        end

        // twice WAYS tags into set 5 forces dirty evictions
        wr_before = wr_count;
        repeat (2) begin
            for (int t = 0; t < 2 * dcache_geom_pkg::WAYS; t++) begin
                store(line_addr(t + 4, 5, t % WPL), 4'hf, lcg_next());
            end
            for (int t = 0; t < 2 * dcache_geom_pkg::WAYS; t++) begin
                load(line_addr(t + 4, 5, t % WPL));
            end
        end
        if (wr_count == wr_before) begin
            errors++;
            $display("no write-back seen while evicting set 5");
        end

        bp_on = 1'b1;
        for (int n = 0; n < N_RAND_OPS; n++) begin
            a = line_addr(rand_below(N_TAGS), rand_below(4), rand_below(WPL));
            if (rand_below(2) != 0) begin
                strb = rand_below(1 << dcache_geom_pkg::STRB_W);
                store(a, strb, lcg_next());
            end else begin
                load(a);
            end
        end
        bp_on = 1'b0;

        @(negedge clk);
        valid = 1'b0;
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, refills %0d, write-backs %0d",
                 checks, errors, rd_count, wr_count);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
// ################################################
// data cache top level, write-back/write-allocate
// CPU request port on one side, burst memory bus
// on the other; ways are generated from WAYS
// ################################################
`default_nettype none

module dcache_top (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire                                     valid,
    input  wire                                     op,
    input  wire dcache_geom_pkg::addr_t             addr,
    input  wire [dcache_geom_pkg::STRB_W-1:0]       wstrb,
    input  wire [dcache_geom_pkg::WORD_W-1:0]       wdata,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic [dcache_geom_pkg::WORD_W-1:0]      rdata,
    input  wire                                     rd_rdy,
    input  wire                                     wr_rdy,
    input  wire                                     ret_valid,
    input  wire                                     ret_last,
    input  wire [dcache_geom_pkg::WORD_W-1:0]       ret_data,
    output logic                                    rd_req,
    output logic [dcache_geom_pkg::ADDR_W-1:0]      rd_addr,
    output logic                                    wr_req,
    output logic [dcache_geom_pkg::ADDR_W-1:0]      wr_addr,
    output logic [dcache_geom_pkg::LINE_W-1:0]      wr_data
);

    wire                                     store_en;
    wire [dcache_geom_pkg::WAYS-1:0]         refill_we;
    wire [dcache_geom_pkg::INDEX_W-1:0]      refill_index;
    wire [dcache_geom_pkg::TAG_W-1:0]        refill_tag;
    wire [dcache_geom_pkg::WORD_SEL_W-1:0]   refill_word;
    wire                                     refill_last;
    wire [dcache_geom_pkg::WAY_W-1:0]        victim_way;
    wire                                     cache_hit;
    wire                                     victim_valid;
    wire                                     victim_dirty;
    wire [dcache_geom_pkg::TAG_W-1:0]        victim_tag;
    wire [dcache_geom_pkg::LINE_W-1:0]       victim_line;

    // per-way lookup results
    wire [dcache_geom_pkg::WAYS-1:0]         way_hit;
    wire [dcache_geom_pkg::WAYS-1:0]         way_valid;
    wire [dcache_geom_pkg::WAYS-1:0]         way_dirty;
    wire [dcache_geom_pkg::WORD_W-1:0]       way_word [dcache_geom_pkg::WAYS];
    wire [dcache_geom_pkg::TAG_W-1:0]        way_tag  [dcache_geom_pkg::WAYS];
    wire [dcache_geom_pkg::LINE_W-1:0]       way_line [dcache_geom_pkg::WAYS];

    dcache_ctrl u_ctrl (
        .clk, .resetn, .valid, .op, .addr,
        .cache_hit, .victim_valid, .victim_dirty, .victim_tag, .victim_line,
        .wr_rdy, .rd_rdy, .ret_valid, .ret_last,
        .addr_ok, .data_ok, .store_en,
        .refill_we, .refill_index, .refill_tag, .refill_word, .refill_last,
        .victim_way, .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data
    );

    for (genvar w = 0; w < dcache_geom_pkg::WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk, .resetn, .addr, .store_en, .wstrb, .wdata,
            .refill_we   (refill_we[w]),
            .refill_index, .refill_tag, .refill_word, .refill_last, .ret_data,
            .hit         (way_hit[w]),
            .rd_word     (way_word[w]),
            .line_valid  (way_valid[w]),
            .line_dirty  (way_dirty[w]),
            .line_tag    (way_tag[w]),
            .line_data   (way_line[w])
        );
    end

    dcache_way_mux u_mux (
        .hit        (way_hit),
        .rd_word    (way_word),
        .line_valid (way_valid),
        .line_dirty (way_dirty),
        .line_tag   (way_tag),
        .line_data  (way_line),
        .victim_way, .cache_hit, .rdata,
        .victim_valid, .victim_dirty, .victim_tag, .victim_line
    );

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
// ################################################
// miss controller of the data cache
// LOOKUP/MISS/REPLACE/REFILL FSM, free-running
// victim counter, miss buffer and refill counter;
// drives the CPU handshake, the bus strobes and
// the write controls of every way
// ################################################
`default_nettype none

module dcache_ctrl (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire                                     valid,
    input  wire                                     op,        // 0 load, 1 store
    input  wire dcache_geom_pkg::addr_t             addr,
    input  wire                                     cache_hit,
    input  wire                                     victim_valid,
    input  wire                                     victim_dirty,
    input  wire [dcache_geom_pkg::TAG_W-1:0]        victim_tag,
    input  wire [dcache_geom_pkg::LINE_W-1:0]       victim_line,
    input  wire                                     wr_rdy,
    input  wire                                     rd_rdy,
    input  wire                                     ret_valid,
    input  wire                                     ret_last,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic                                    store_en,
    output logic [dcache_geom_pkg::WAYS-1:0]        refill_we,
    output logic [dcache_geom_pkg::INDEX_W-1:0]     refill_index,
    output logic [dcache_geom_pkg::TAG_W-1:0]       refill_tag,
    output logic [dcache_geom_pkg::WORD_SEL_W-1:0]  refill_word,
    output logic                                    refill_last,
    output logic [dcache_geom_pkg::WAY_W-1:0]       victim_way,
    output logic                                    rd_req,
    output logic [dcache_geom_pkg::ADDR_W-1:0]      rd_addr,
    output logic                                    wr_req,
    output logic [dcache_geom_pkg::ADDR_W-1:0]      wr_addr,
    output logic [dcache_geom_pkg::LINE_W-1:0]      wr_data
);

    logic [dcache_ctrl_pkg::STATE_W-1:0]      state_q;
    logic [dcache_ctrl_pkg::STATE_W-1:0]      state_d;
    logic [dcache_geom_pkg::WAY_W-1:0]        rnd_q;      // "random" way
    logic [dcache_ctrl_pkg::REFILL_CNT_W-1:0] ret_cnt_q;

    // miss buffer
    logic [dcache_geom_pkg::WAY_W-1:0]   mb_way;
    logic                                mb_valid;
    logic                                mb_dirty;
    logic [dcache_geom_pkg::TAG_W-1:0]   mb_tag_old;
    logic [dcache_geom_pkg::TAG_W-1:0]   mb_tag_new;
    logic [dcache_geom_pkg::INDEX_W-1:0] mb_index;
    logic [dcache_geom_pkg::LINE_W-1:0]  mb_line;

    dcache_geom_pkg::addr_t rd_a;
    dcache_geom_pkg::addr_t wr_a;
    logic                   need_wb;

    assign need_wb = mb_valid && mb_dirty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_ctrl_pkg::ST_LOOKUP: begin
                if (valid && !cache_hit) begin
                    state_d = dcache_ctrl_pkg::ST_MISS;
                end
            end
            dcache_ctrl_pkg::ST_MISS: begin
                if (need_wb && wr_rdy) begin
                    state_d = dcache_ctrl_pkg::ST_REPLACE;
                end else if (!need_wb && rd_rdy) begin
                    state_d = dcache_ctrl_pkg::ST_REFILL;  // clean victim needs no write-back
                end
            end
            dcache_ctrl_pkg::ST_REPLACE: begin
                if (rd_rdy) begin
                    state_d = dcache_ctrl_pkg::ST_REFILL;
                end
            end
            default: begin
                if (ret_valid && ret_last) begin
                    state_d = dcache_ctrl_pkg::ST_LOOKUP;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= dcache_ctrl_pkg::ST_LOOKUP;
            rnd_q   <= '0;
        end else begin
            state_q <= state_d;
            rnd_q   <= rnd_q + 1'b1;
        end
    end

    // refreshed on every LOOKUP cycle and frozen through the miss
    always_ff @(posedge clk) begin
        if (state_q == dcache_ctrl_pkg::ST_LOOKUP) begin
            mb_way     <= rnd_q;
            mb_valid   <= victim_valid;
            mb_dirty   <= victim_dirty;
            mb_tag_old <= victim_tag;
            mb_tag_new <= addr.f.tag;
            mb_index   <= addr.f.index;
            mb_line    <= victim_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ret_cnt_q <= '0;
        end else if (rd_req) begin
            ret_cnt_q <= '0;
        end else if (ret_valid) begin
            ret_cnt_q <= ret_cnt_q + 1'b1;
        end
    end

    // CPU side
    assign addr_ok  = (state_q == dcache_ctrl_pkg::ST_LOOKUP) &&
                      (state_d == dcache_ctrl_pkg::ST_LOOKUP);
    assign data_ok  = (state_q == dcache_ctrl_pkg::ST_LOOKUP) && valid && cache_hit;
    assign store_en = data_ok && op;

    // way writes
    always_comb begin
        refill_we = '0;
        if (state_q == dcache_ctrl_pkg::ST_REFILL && ret_valid) begin
            refill_we[mb_way] = 1'b1;
        end
    end

    assign refill_index = mb_index;
    assign refill_tag   = mb_tag_new;
    assign refill_word  = ret_cnt_q;
    assign refill_last  = ret_last;
    assign victim_way   = rnd_q;

    // both bus addresses are line aligned
    always_comb begin
        rd_a.f.tag      = mb_tag_new;
        rd_a.f.index    = mb_index;
        rd_a.f.word_sel = '0;
        rd_a.f.byte_off = '0;
        wr_a.f.tag      = mb_tag_old;
        wr_a.f.index    = mb_index;
        wr_a.f.word_sel = '0;
        wr_a.f.byte_off = '0;
    end

    assign rd_addr = rd_a.flat;
    assign wr_addr = wr_a.flat;
    assign wr_data = mb_line;
    assign wr_req  = (state_q == dcache_ctrl_pkg::ST_MISS) && need_wb && wr_rdy;
    assign rd_req  = (state_d == dcache_ctrl_pkg::ST_REFILL) &&
                     (state_q != dcache_ctrl_pkg::ST_REFILL);

    // memory only returns data it was asked for
    a_ret_in_refill: assert property (
        @(posedge clk) disable iff (!resetn)
        ret_valid |-> state_q == dcache_ctrl_pkg::ST_REFILL
    ) else $error("ret_valid outside REFILL");

    // the final return word of a line carries ret_last
    a_ret_last_cnt: assert property (
        @(posedge clk) disable iff (!resetn)
        ret_valid |-> ret_last == (ret_cnt_q == '1)
    ) else $error("ret_last not on the last word of the line");

endmodule

`default_nettype wire

// File: hdl/dcache_way_mux.sv
// ################################################
// combines the per-way lookup results
// hit OR and load word select toward the CPU,
// victim state select toward the controller
// ################################################
`default_nettype none

module dcache_way_mux (
    input  wire [dcache_geom_pkg::WAYS-1:0]     hit,
    input  wire [dcache_geom_pkg::WORD_W-1:0]   rd_word   [dcache_geom_pkg::WAYS],
    input  wire [dcache_geom_pkg::WAYS-1:0]     line_valid,
    input  wire [dcache_geom_pkg::WAYS-1:0]     line_dirty,
    input  wire [dcache_geom_pkg::TAG_W-1:0]    line_tag  [dcache_geom_pkg::WAYS],
    input  wire [dcache_geom_pkg::LINE_W-1:0]   line_data [dcache_geom_pkg::WAYS],
    input  wire [dcache_geom_pkg::WAY_W-1:0]    victim_way,
    output logic                                cache_hit,
    output logic [dcache_geom_pkg::WORD_W-1:0]  rdata,
    output logic                                victim_valid,
    output logic                                victim_dirty,
    output logic [dcache_geom_pkg::TAG_W-1:0]   victim_tag,
    output logic [dcache_geom_pkg::LINE_W-1:0]  victim_line
);

    assign cache_hit = |hit;

    // and-or select, zero when nothing hits
    always_comb begin
        rdata = '0;
        for (int w = 0; w < dcache_geom_pkg::WAYS; w++) begin
            if (hit[w]) begin
                rdata = rdata | rd_word[w];
            end
        end
    end

    assign victim_valid = line_valid[victim_way];
    assign victim_dirty = line_dirty[victim_way];
    assign victim_tag   = line_tag[victim_way];
    assign victim_line  = line_data[victim_way];

    // a tag lives in at most one way of a set, refill only after a miss
    always_comb begin
        a_one_hit: assert final ($isunknown(hit) || $onehot0(hit))
            else $error("more than one way hits: %b", hit);
    end

endmodule

`default_nettype wire

// File: hdl/dcache_way.sv
// ################################################
// one way of the set-associative data cache
// valid/dirty/tag/data arrays with a combinational
// lookup at the CPU index; store hits merge bytes,
// refill words come in from the bus one at a time
// ################################################
`default_nettype none

module dcache_way (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire dcache_geom_pkg::addr_t             addr,
    input  wire                                     store_en,
    input  wire [dcache_geom_pkg::STRB_W-1:0]       wstrb,
    input  wire [dcache_geom_pkg::WORD_W-1:0]       wdata,
    input  wire                                     refill_we,
    input  wire [dcache_geom_pkg::INDEX_W-1:0]      refill_index,
    input  wire [dcache_geom_pkg::TAG_W-1:0]        refill_tag,
    input  wire [dcache_geom_pkg::WORD_SEL_W-1:0]   refill_word,
    input  wire                                     refill_last,
    input  wire [dcache_geom_pkg::WORD_W-1:0]       ret_data,
    output logic                                    hit,
    output logic [dcache_geom_pkg::WORD_W-1:0]      rd_word,
    output logic                                    line_valid,
    output logic                                    line_dirty,
    output logic [dcache_geom_pkg::TAG_W-1:0]       line_tag,
    output logic [dcache_geom_pkg::LINE_W-1:0]      line_data
);

    logic [dcache_geom_pkg::SETS-1:0]   valid_q;
    logic [dcache_geom_pkg::SETS-1:0]   dirty_q;
    logic [dcache_geom_pkg::TAG_W-1:0]  tag_q  [dcache_geom_pkg::SETS];
    logic [dcache_geom_pkg::WORD_W-1:0] data_q [dcache_geom_pkg::SETS]
                                               [dcache_geom_pkg::WORDS_PER_LINE];

    // lookup at the CPU set
    assign line_valid = valid_q[addr.f.index];
    assign line_dirty = dirty_q[addr.f.index];
    assign line_tag   = tag_q[addr.f.index];
    assign hit        = line_valid && (line_tag == addr.f.tag);
    assign rd_word    = data_q[addr.f.index][addr.f.word_sel];

    always_comb begin
        for (int w = 0; w < dcache_geom_pkg::WORDS_PER_LINE; w++) begin
            line_data[w*dcache_geom_pkg::WORD_W +: dcache_geom_pkg::WORD_W] =
                data_q[addr.f.index][w];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (refill_we && refill_last) begin
            valid_q[refill_index] <= 1'b1;  // line usable only once complete
            dirty_q[refill_index] <= 1'b0;
        end else if (store_en && hit) begin
            dirty_q[addr.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            data_q[refill_index][refill_word] <= ret_data;
            if (refill_last) begin
                tag_q[refill_index] <= refill_tag;
            end
        end else if (store_en && hit) begin
            // lane-aligned byte merge
            for (int b = 0; b < dcache_geom_pkg::STRB_W; b++) begin
                if (wstrb[b]) begin
                    data_q[addr.f.index][addr.f.word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // stores only happen in LOOKUP, refills only in REFILL
    a_store_refill_excl: assert property (
        @(posedge clk) disable iff (!resetn) !(store_en && hit && refill_we)
    ) else $error("store hit and refill write in the same cycle");

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl_pkg.sv
// ################################################
// controller encodings for the data cache
// state codes of the miss FSM and the width of
// the refill word counter
// ################################################
`default_nettype none

package dcache_ctrl_pkg;

    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] ST_LOOKUP  = 2'd0;  // idle or hit
    localparam logic [STATE_W-1:0] ST_MISS    = 2'd1;  // victim known, waiting on bus
    localparam logic [STATE_W-1:0] ST_REPLACE = 2'd2;  // dirty line handed to bus
    localparam logic [STATE_W-1:0] ST_REFILL  = 2'd3;  // collecting return words

    // one count per returned word
    localparam int REFILL_CNT_W = dcache_geom_pkg::WORD_SEL_W;

endpackage

`default_nettype wire

// File: hdl/dcache_geom_pkg.sv
// ################################################
// cache geometry shared by every RTL module
// sizes must stay powers of two, widths follow them
// addr_t splits a CPU/bus address into tag, set,
// word and byte fields or gives the flat word
// ################################################
`default_nettype none

package dcache_geom_pkg;

    localparam int WAYS           = 4;
    localparam int WAY_W          = $clog2(WAYS);
    localparam int SETS           = 16;
    localparam int INDEX_W        = $clog2(SETS);
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
    localparam int WORD_W         = 32;
    localparam int STRB_W         = WORD_W / 8;
    localparam int BYTE_OFF_W     = $clog2(STRB_W);
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;  // whole line, word 0 at lsb
    localparam int ADDR_W         = 32;
    localparam int TAG_W          = ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;

    // field view for lookup, flat view for the bus
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [INDEX_W-1:0]    index;
            logic [WORD_SEL_W-1:0] word_sel;
            logic [BYTE_OFF_W-1:0] byte_off;
        } f;
        logic [ADDR_W-1:0] flat;
    } addr_t;

endpackage

`default_nettype wire
